//--- common/fft_pkg.sv
// Shared types and constants of the 8-point SDF FFT
// Complex sample structs for each stage width, twiddle and phase encodings
package fft_pkg;

    // Number of points in one frame
    localparam int FFT_N = 8;

    // sqrt(2)/2 in Q1.14, applied to the W1 and W3 twiddles
    localparam logic signed [15:0] TW_C = 16'sd11585;
    localparam int TW_SHIFT = 14;                     // Drops the Q1.14 fraction after a multiply

    // Stage input, 16 bit parts
    typedef struct packed {
        logic signed [15:0] re;
        logic signed [15:0] im;
    } cplx16_t;

    // Stage 1 output
    typedef struct packed {
        logic signed [16:0] re;
        logic signed [16:0] im;
    } cplx17_t;

    // Stage 2 output
    typedef struct packed {
        logic signed [17:0] re;
        logic signed [17:0] im;
    } cplx18_t;

    // Stage 3 output, the result of the FFT
    typedef struct packed {
        logic signed [18:0] re;
        logic signed [18:0] im;
    } cplx19_t;

    // The value is the power of W8
    typedef enum logic [1:0] {
        TW_ONE = 2'd0,  // 1
        TW_W1  = 2'd1,  // (1-j)/sqrt(2)
        TW_MJ  = 2'd2,  // -j
        TW_W3  = 2'd3   // (-1-j)/sqrt(2)
    } twiddle_e;

    typedef enum logic {
        PH_FILL = 1'b0, // Input goes into the delay line, stored difference goes out
        PH_BFLY = 1'b1  // Sum goes out, difference goes into the delay line
    } phase_e;

endpackage

//--- sdf_stage/delay_line.sv
// Feedback delay line of an SDF stage
// Shift register of DEPTH complex samples, shifts on every clock
`timescale 1ns/1ps

module delay_line #(
    parameter int  DEPTH = 4,
    parameter type T     = logic [31:0]
) (
    input  logic clk,
    input  logic rst,
    input  T     data_i,
    output T     data_o
);

    T [DEPTH-1:0] sr;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sr <= '0;
        end else begin
            sr[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

    // Oldest entry goes back to the butterfly
    assign data_o = sr[DEPTH-1];

endmodule

//--- sdf_stage/butterfly_r2.sv
// Radix-2 DIF butterfly with trivial twiddle multiplication
// Sums and differences in the butterfly phase, twiddled differences in the fill phase
`timescale 1ns/1ps

module butterfly_r2 import fft_pkg::*; #(
    parameter type in_t  = cplx16_t,
    parameter type out_t = cplx17_t
) (
    input  phase_e   phase_i,
    input  twiddle_e twiddle_i,
    input  in_t      a_i,       // New sample from the input register
    input  out_t     b_i,       // Sample coming back from the delay line
    output out_t     out_o,
    output out_t     sr_o       // Into the delay line
);

    localparam int WO = $bits(out_t) / 2;

    logic signed [WO-1:0] a_re;
    logic signed [WO-1:0] a_im;
    logic signed [WO:0]   b_re;
    logic signed [WO:0]   b_im;
    logic signed [WO:0]   sum_ri;   // re + im
    logic signed [WO:0]   dif_ir;   // im - re
    logic signed [WO:0]   neg_ri;   // -re - im
    logic signed [WO-1:0] w_re;
    logic signed [WO-1:0] w_im;

    // Multiply by sqrt(2)/2 and truncate back to the output width
    function automatic logic signed [WO-1:0] tw_mul(input logic signed [WO:0] x);
        logic signed [WO+16:0] prod;
        prod = x * TW_C;
        return WO'(prod >>> TW_SHIFT);
    endfunction

    // Sign extension happens on assignment
    assign a_re = a_i.re;
    assign a_im = a_i.im;

    // One bit wider so the twiddle sums cannot wrap
    assign b_re = b_i.re;
    assign b_im = b_i.im;

    assign sum_ri = b_re + b_im;
    assign dif_ir = b_im - b_re;
    assign neg_ri = -b_re - b_im;

    always_comb begin
        case (twiddle_i)
            TW_W1: begin
                w_re = tw_mul(sum_ri);
                w_im = tw_mul(dif_ir);
            end
            TW_MJ: begin
                w_re = b_i.im;              // Rotate by -90 degrees
                w_im = -b_i.re;
            end
            TW_W3: begin
                w_re = tw_mul(dif_ir);
                w_im = tw_mul(neg_ri);
            end
            default: begin
                w_re = b_i.re;
                w_im = b_i.im;
            end
        endcase
    end

    always_comb begin
        if (phase_i == PH_BFLY) begin
            out_o.re = b_i.re + a_re;       // x[n] + x[n+DELAY]
            out_o.im = b_i.im + a_im;
            sr_o.re  = b_i.re - a_re;       // Difference waits DELAY cycles for its slot
            sr_o.im  = b_i.im - a_im;
        end else begin
            out_o.re = w_re;
            out_o.im = w_im;
            sr_o.re  = a_re;
            sr_o.im  = a_im;
        end
    end

endmodule

//--- sdf_stage/stage_ctrl.sv
// SDF stage controller
// Tracks the frame position of the registered sample, selects phase and twiddle,
// and delays the valid so it lines up with the butterfly output
`timescale 1ns/1ps

module stage_ctrl import fft_pkg::*; #(
    parameter int DELAY = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_i,   // Valid of the registered sample
    output phase_e   phase_o,
    output twiddle_e twiddle_o,
    output logic     valid_o
);

    localparam int CW   = $clog2(2 * DELAY);
    localparam int STEP = 4 / DELAY;    // Twiddle power step per position, W8^(c*4/DELAY)

    // Pipe stages that still feed the counter on the next cycle, all but the last one
    localparam logic [DELAY-1:0] PEND_MASK = {DELAY{1'b1}} >> 1;

    logic [CW-1:0]    cnt;
    logic [DELAY-1:0] vpipe;
    logic             pending;
    logic [1:0]       tw_pow;

    // Keep counting while a frame is in or its differences are still draining.
    // A new frame therefore has to start back to back or after the drain is over
    assign pending = valid_i || |(vpipe & PEND_MASK);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (!pending) begin
            cnt <= '0;                          // Idle, next sample starts at position 0
        end else if (cnt == CW'(2 * DELAY - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // The valid pipe runs DELAY deep, the stage input register adds the last cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vpipe <= '0;
        end else begin
            vpipe <= DELAY'({vpipe, valid_i});
        end
    end

    assign valid_o = vpipe[DELAY-1];

    assign tw_pow = 2'(cnt * STEP);

    // First half of the frame fills the delay line, second half does the butterfly
    always_comb begin
        if (cnt < CW'(DELAY)) begin
            phase_o   = PH_FILL;
            twiddle_o = twiddle_e'(tw_pow);
        end else begin
            phase_o   = PH_BFLY;
            twiddle_o = TW_ONE;     // Not used while summing
        end
    end

endmodule

//--- sdf_stage/sdf_stage.sv
// One radix-2 SDF stage
// Input register, controller, feedback delay line and butterfly
// Output follows the input by DELAY+1 cycles
`timescale 1ns/1ps

module sdf_stage import fft_pkg::*; #(
    parameter int  DELAY = 4,
    parameter type in_t  = cplx16_t,
    parameter type out_t = cplx17_t
) (
    input  logic clk,
    input  logic rst,
    input  logic valid_i,
    input  in_t  data_i,
    output logic valid_o,
    output out_t data_o
);

    in_t      data_r;   // Registered sample, butterfly operand A
    logic     valid_r;
    phase_e   phase;
    twiddle_e twiddle;
    out_t     sr_in;    // Butterfly into the delay line
    out_t     fb_out;   // Delay line back into the butterfly

    // Every stage input is registered, so no combinational path crosses stages
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_r  <= '0;
            valid_r <= 1'b0;
        end else begin
            data_r  <= data_i;
            valid_r <= valid_i;
        end
    end

    stage_ctrl #(
        .DELAY (DELAY)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (valid_r),
        .phase_o   (phase),
        .twiddle_o (twiddle),
        .valid_o   (valid_o)
    );

    delay_line #(
        .DEPTH (DELAY),
        .T     (out_t)
    ) u_delay (
        .clk    (clk),
        .rst    (rst),
        .data_i (sr_in),
        .data_o (fb_out)
    );

    butterfly_r2 #(
        .in_t  (in_t),
        .out_t (out_t)
    ) u_bfly (
        .phase_i   (phase),
        .twiddle_i (twiddle),
        .a_i       (data_r),
        .b_i       (fb_out),
        .out_o     (data_o),
        .sr_o      (sr_in)
    );

endmodule

//--- design/sdf_fft8_top.sv
// 8-point radix-2 SDF FFT, decimation in frequency
// Three stages with feedback delays 4, 2 and 1, output in bit-reversed order
// Fixed latency of 10 cycles, each stage adds one bit of growth
`timescale 1ns/1ps

module sdf_fft8_top import fft_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    valid_i,
    input  cplx16_t data_i,
    output logic    valid_o,
    output cplx19_t data_o
);

    logic    valid_s1;
    cplx17_t data_s1;
    logic    valid_s2;
    cplx18_t data_s2;

    // First stage pairs x[n] with x[n+4]
    sdf_stage #(
        .DELAY (4),
        .in_t  (cplx16_t),
        .out_t (cplx17_t)
    ) u_stage1 (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .data_i  (data_i),
        .valid_o (valid_s1),
        .data_o  (data_s1)
    );

    sdf_stage #(
        .DELAY (2),
        .in_t  (cplx17_t),
        .out_t (cplx18_t)
    ) u_stage2 (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_s1),
        .data_i  (data_s1),
        .valid_o (valid_s2),
        .data_o  (data_s2)
    );

    // Last stage only needs the trivial twiddle
    sdf_stage #(
        .DELAY (1),
        .in_t  (cplx18_t),
        .out_t (cplx19_t)
    ) u_stage3 (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_s2),
        .data_i  (data_s2),
        .valid_o (valid_o),
        .data_o  (data_o)
    );

endmodule

//--- tests/fft_model.svh
// Fixed-point reference model of the 8-point DIF pipeline
// Computes a whole frame and returns it in the order the DUT streams it out
`ifndef FFT_MODEL_SVH
`define FFT_MODEL_SVH

// Reverses the three index bits of a frame position
function automatic int bitrev3(input int k);
    return ((k & 1) << 2) | (k & 2) | ((k >> 2) & 1);
endfunction

// Keeps the low w bits of v as a two's complement value
function automatic longint wrap_bits(input longint v, input int w);
    longint m;
    longint r;
    m = longint'(1) << w;
    r = v & (m - 1);
    if (r >= m / 2) begin
        r = r - m;
    end
    return r;
endfunction

// Multiply by sqrt(2)/2 in Q1.14, the shift rounds toward minus infinity
function automatic longint scale_c(input longint x, input int w);
    return wrap_bits((x * longint'(TW_C)) >>> TW_SHIFT, w);
endfunction

task automatic fft_model(input int x_re [8], input int x_im [8],
                         output int y_re [8], output int y_im [8]);
    longint a_re [8];
    longint a_im [8];
    longint d_re;
    longint d_im;
    int     w;
    int     i;
    int     j;
    w = 16;
    for (int k = 0; k < 8; k++) begin
        a_re[k] = x_re[k];
        a_im[k] = x_im[k];
    end
    for (int span = 4; span >= 1; span = span / 2) begin
        w = w + 1;                          // One bit of growth per stage
        for (int base = 0; base < 8; base = base + 2 * span) begin
            for (int n = 0; n < span; n++) begin
                i = base + n;
                j = i + span;
                d_re = wrap_bits(a_re[i] - a_re[j], w);
                d_im = wrap_bits(a_im[i] - a_im[j], w);
                a_re[i] = wrap_bits(a_re[i] + a_re[j], w);
                a_im[i] = wrap_bits(a_im[i] + a_im[j], w);
                // Power of W8 applied to the difference
                case (n * (4 / span))
                    1: begin
                        a_re[j] = scale_c(d_re + d_im, w);
                        a_im[j] = scale_c(d_im - d_re, w);
                    end
                    2: begin
                        a_re[j] = d_im;
                        a_im[j] = wrap_bits(-d_re, w);
                    end
                    3: begin
                        a_re[j] = scale_c(d_im - d_re, w);
                        a_im[j] = scale_c(-d_re - d_im, w);
                    end
                    default: begin
                        a_re[j] = d_re;
                        a_im[j] = d_im;
                    end
                endcase
            end
        end
    end
    // In-place DIF leaves bin bitrev3(p) at position p, which is the order the DUT streams
    for (int p = 0; p < 8; p++) begin
        y_re[p] = int'(a_re[p]);
        y_im[p] = int'(a_im[p]);
    end
endtask

`endif

//--- tests/tb_sdf_fft8.sv
// Directed testbench for the 8-point SDF FFT
// Checks valid framing, latency and output samples against a fixed-point model
`timescale 1ns/1ps

module tb_sdf_fft8 import fft_pkg::*; ();

    localparam int NUM_TESTS       = 6;
    localparam int NUM_FRAMES      = 12;
    localparam int LATENCY         = 10;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * FFT_N + NUM_TESTS * 100;

    logic    clk;
    logic    rst;
    logic    valid_i;
    cplx16_t data_i;
    logic    valid_o;
    cplx19_t data_o;

    int        cyc = 0;                 // Rising edges since time zero
    bit [31:0] lcg_state = 32'h3731;
    cplx19_t   out_q [$];
    int        out_cyc [$];             // Cycle in which each output was seen

    sdf_fft8_top DUT (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .data_i  (data_i),
        .valid_o (valid_o),
        .data_o  (data_o)
    );

    `include "fft_model.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Outputs are sampled mid-cycle where data_o has settled
    always @(negedge clk) begin
        if (rst && valid_o === 1'b1) begin
            out_q.push_back(data_o);
            out_cyc.push_back(cyc);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

    function automatic bit [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic make_random_frame(output int f_re [8], output int f_im [8]);
        for (int i = 0; i < FFT_N; i++) begin
            f_re[i] = int'((lcg_next() >> 16) % 32'd16383) - 8191;     // Within +-8191
            f_im[i] = int'((lcg_next() >> 16) % 32'd16383) - 8191;
        end
    endtask

    task automatic drive_frame(input int f_re [8], input int f_im [8], output int start);
        for (int i = 0; i < FFT_N; i++) begin
            @(posedge clk);
            #2;
            valid_i   = 1'b1;
            data_i.re = 16'(f_re[i]);
            data_i.im = 16'(f_im[i]);
            if (i == 0) start = cyc;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            valid_i = 1'b0;
            data_i  = '0;
        end
    endtask

    task automatic clear_outputs();
        out_q.delete();
        out_cyc.delete();
    endtask

    task automatic wait_outputs(input int n);
        int waited;
        waited = 0;
        while (out_q.size() < n) begin
            @(posedge clk);
            waited++;
            assert (waited <= 64) else
                abort_run($sformatf("Timeout: waited for %0d output samples, only %0d came",
                                    n, out_q.size()));
        end
    endtask

    task automatic check_output(input int idx, input int exp_re, input int exp_im);
        cplx19_t got;
        got = out_q[idx];
        assert (int'(got.re) == exp_re) else
            abort_run($sformatf("FAIL at time %0t: data_o.re of output %0d expected %0d, got %0d",
                                $time, idx, exp_re, int'(got.re)));
        assert (int'(got.im) == exp_im) else
            abort_run($sformatf("FAIL at time %0t: data_o.im of output %0d expected %0d, got %0d",
                                $time, idx, exp_im, int'(got.im)));
    endtask

    task automatic check_timing(input int idx, input int exp_cyc);
        assert (out_cyc[idx] == exp_cyc) else
            abort_run($sformatf(
                "FAIL at time %0t: valid_o of output %0d expected in cycle %0d, got %0d",
                $time, idx, exp_cyc, out_cyc[idx]));
    endtask

    task automatic test_idle_quiet();
        repeat (20) begin
            @(negedge clk);
            assert (valid_o === 1'b0) else
                abort_run($sformatf("FAIL at time %0t: valid_o expected 0, got %b",
                                    $time, valid_o));
        end
    endtask

    // All differences vanish, only bin 0 carries the sum
    task automatic test_constant(input int v);
        int f_re [8];
        int f_im [8];
        int start;
        int exp_v;
        clear_outputs();
        for (int i = 0; i < 8; i++) begin
            f_re[i] = v;
            f_im[i] = v;
        end
        drive_frame(f_re, f_im, start);
        idle(1);
        wait_outputs(8);
        for (int k = 0; k < 8; k++) begin
            exp_v = (bitrev3(k) == 0) ? 8 * v : 0;     // Slot k carries bin bitrev3(k)
            check_output(k, exp_v, exp_v);
        end
    endtask

    task automatic test_impulse(input int pos);
        int f_re [8];
        int f_im [8];
        int y_re [8];
        int y_im [8];
        int start;
        clear_outputs();
        for (int i = 0; i < 8; i++) begin
            f_re[i] = (i == pos) ? 1000 : 0;
            f_im[i] = 0;
        end
        fft_model(f_re, f_im, y_re, y_im);
        drive_frame(f_re, f_im, start);
        idle(1);
        wait_outputs(8);
        for (int k = 0; k < 8; k++) check_output(k, y_re[k], y_im[k]);
    endtask

    task automatic test_latency();
        int f_re [8];
        int f_im [8];
        int y_re [8];
        int y_im [8];
        int start;
        clear_outputs();
        make_random_frame(f_re, f_im);
        fft_model(f_re, f_im, y_re, y_im);
        drive_frame(f_re, f_im, start);
        idle(1);
        wait_outputs(8);
        @(negedge clk);                 // Cycle right after the last output
        assert (valid_o === 1'b0) else
            abort_run($sformatf("FAIL at time %0t: valid_o expected 0, got %b", $time, valid_o));
        repeat (4) @(negedge clk);
        assert (out_q.size() == 8) else
            abort_run($sformatf("FAIL at time %0t: valid_o count expected 8, got %0d",
                                $time, out_q.size()));
        for (int k = 0; k < 8; k++) begin
            check_timing(k, start + LATENCY + k);
            check_output(k, y_re[k], y_im[k]);
        end
    endtask

    task automatic test_back_to_back();
        int f_re [8];
        int f_im [8];
        int y_re [8];
        int y_im [8];
        int e_re [32];
        int e_im [32];
        int start;
        int first;
        clear_outputs();
        for (int f = 0; f < 4; f++) begin
            make_random_frame(f_re, f_im);
            fft_model(f_re, f_im, y_re, y_im);
            for (int k = 0; k < 8; k++) begin
                e_re[f * 8 + k] = y_re[k];
                e_im[f * 8 + k] = y_im[k];
            end
            drive_frame(f_re, f_im, start);
            if (f == 0) first = start;
        end
        idle(1);
        wait_outputs(32);
        for (int k = 0; k < 32; k++) begin
            check_timing(k, first + LATENCY + k);   // No hole in valid_o across frames
            check_output(k, e_re[k], e_im[k]);
        end
    endtask

    // Five idle cycles put a free-running counter off its frame boundary
    task automatic test_gap_realign();
        int f_re [8];
        int f_im [8];
        int y_re [16];
        int y_im [16];
        int r_re [8];
        int r_im [8];
        int start [2];
        clear_outputs();
        for (int f = 0; f < 2; f++) begin
            make_random_frame(f_re, f_im);
            fft_model(f_re, f_im, r_re, r_im);
            for (int k = 0; k < 8; k++) begin
                y_re[f * 8 + k] = r_re[k];
                y_im[f * 8 + k] = r_im[k];
            end
            drive_frame(f_re, f_im, start[f]);
            idle((f == 0) ? 5 : 1);
        end
        wait_outputs(16);
        for (int k = 0; k < 16; k++) begin
            check_timing(k, start[k / 8] + LATENCY + k % 8);
            check_output(k, y_re[k], y_im[k]);
        end
    endtask

    initial begin
        rst     = 1'b0;
        valid_i = 1'b0;
        data_i  = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;
        test_idle_quiet();
        test_constant(1234);
        test_constant(-4321);
        test_impulse(0);
        test_impulse(1);                // W1 on the first stage difference
        test_impulse(3);                // W3 on the first stage difference
        test_latency();
        test_back_to_back();
        test_gap_realign();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- sdf_fft8.f
+incdir+tests
common/fft_pkg.sv
sdf_stage/delay_line.sv
sdf_stage/butterfly_r2.sv
sdf_stage/stage_ctrl.sv
sdf_stage/sdf_stage.sv
design/sdf_fft8_top.sv
tests/tb_sdf_fft8.sv

//--- Bender.yml
package:
  name: sdf_fft8

sources:
  # Shared package first, then the stage blocks and the top level
  - common/fft_pkg.sv
  - sdf_stage/delay_line.sv
  - sdf_stage/butterfly_r2.sv
  - sdf_stage/stage_ctrl.sv
  - sdf_stage/sdf_stage.sv
  - design/sdf_fft8_top.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_sdf_fft8.sv
